// File: all.f
hw/axi_lite_regs_pkg.sv
hw/reg_addr_decode.sv
hw/spill_register.sv
hw/axi_lite_regs.sv
hw/axi_lite_regs_top.sv
tests/axi_lite_regs_props.sv
tests/tb_axi_lite_regs.sv

// File: hw/axi_lite_regs.sv
`timescale 1ns/1ns

module axi_lite_regs (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Write address and data
  input  axi_lite_regs_pkg::axi_addr_t aw_addr_i,
  input  axi_lite_regs_pkg::axi_prot_t aw_prot_i,
  input  logic                         aw_valid_i,
  output logic                         aw_ready_o,
  input  axi_lite_regs_pkg::axi_data_t w_data_i,
  input  axi_lite_regs_pkg::axi_strb_t w_strb_i,
  input  logic                         w_valid_i,
  output logic                         w_ready_o,
  // Write response toward the B buffer
  output logic                         b_valid_o,
  input  logic                         b_ready_i,
  output logic [axi_lite_regs_pkg::B_WIDTH-1:0] b_payload_o,
  // Read address
  input  axi_lite_regs_pkg::axi_addr_t ar_addr_i,
  input  axi_lite_regs_pkg::axi_prot_t ar_prot_i,
  input  logic                         ar_valid_i,
  output logic                         ar_ready_o,
  // Read response toward the R buffer
  output logic                         r_valid_o,
  input  logic                         r_ready_i,
  output logic [axi_lite_regs_pkg::R_WIDTH-1:0] r_payload_o,
  // Map base and register values
  input  axi_lite_regs_pkg::axi_addr_t base_addr_i,
  input  logic [axi_lite_regs_pkg::NUM_REGS*axi_lite_regs_pkg::REG_WIDTH-1:0] reg_init_i,
  output logic [axi_lite_regs_pkg::NUM_REGS*axi_lite_regs_pkg::REG_WIDTH-1:0] reg_q_o
);
  import axi_lite_regs_pkg::*;

  // Unpacked views of the flat register vectors
  reg_data_t reg_init [NUM_REGS];
  reg_data_t reg_q    [NUM_REGS];

  // Write side
  reg_idx_t  aw_idx;
  logic      aw_hit;
  logic      aw_prot_ok;
  logic      wr_req;
  logic      wr_ok;
  logic      wr_en;
  reg_data_t reg_d;

  // Read side
  reg_idx_t  ar_idx;
  logic      ar_hit;
  logic      ar_prot_ok;
  logic      rd_ok;
  axi_data_t rd_data;
  axi_resp_t rd_resp;

  reg_addr_decode u_aw_decode (
    .addr_i      (aw_addr_i),
    .base_addr_i (base_addr_i),
    .idx_o       (aw_idx),
    .hit_o       (aw_hit)
  );

  reg_addr_decode u_ar_decode (
    .addr_i      (ar_addr_i),
    .base_addr_i (base_addr_i),
    .idx_o       (ar_idx),
    .hit_o       (ar_hit)
  );

  // Prot bit 0 is privileged, bit 1 is secure
  assign aw_prot_ok = (PRIV_PROT_ONLY ? aw_prot_i[0] : 1'b1) &
                      (SECU_PROT_ONLY ? aw_prot_i[1] : 1'b1);
  assign ar_prot_ok = (PRIV_PROT_ONLY ? ar_prot_i[0] : 1'b1) &
                      (SECU_PROT_ONLY ? ar_prot_i[1] : 1'b1);

  // Both AW and W must be present before anything happens
  assign wr_req = aw_valid_i & w_valid_i;
  assign wr_ok  = aw_hit & aw_prot_ok & ~READ_ONLY[aw_idx];
  // Stalled write rewrites the same data until B takes it
  assign wr_en  = wr_req & wr_ok;

  // Handshake only completes once B buffer has room
  assign aw_ready_o  = wr_req & b_ready_i;
  assign w_ready_o   = wr_req & b_ready_i;
  assign b_valid_o   = wr_req;
  assign b_payload_o = wr_ok ? RESP_OKAY : RESP_SLVERR;

  // Strobe merge, bytes above REG_WIDTH are dropped
  always_comb begin
    reg_d = reg_q[aw_idx];
    for (int unsigned b = 0; b < REG_WIDTH / 8; b++) begin
      if (w_strb_i[b]) begin
        reg_d[b*8 +: 8] = w_data_i[b*8 +: 8];
      end
    end
  end

  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_regs
    assign reg_init[i] = reg_init_i[i*REG_WIDTH +: REG_WIDTH];
    assign reg_q_o[i*REG_WIDTH +: REG_WIDTH] = reg_q[i];

    if (READ_ONLY[i]) begin : gen_ro
      // No storage, the init input shows through
      assign reg_q[i] = reg_init[i];
    end else begin : gen_rw
      reg_data_t q;

      // Loads init value while reset is held
      always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
          q <= reg_init[i];
        end else if (wr_en && (aw_idx == reg_idx_t'(i))) begin
          q <= reg_d;
        end
      end

      assign reg_q[i] = q;
    end
  end

  // Read response formed straight from the request
  assign rd_ok   = ar_hit & ar_prot_ok;
  assign rd_data = rd_ok ? axi_data_t'(reg_q[ar_idx]) : ERR_DATA;
  assign rd_resp = rd_ok ? RESP_OKAY : RESP_SLVERR;

  // Data in the upper bits, resp in the low two
  assign r_payload_o = {rd_data, rd_resp};
  assign r_valid_o   = ar_valid_i;
  assign ar_ready_o  = r_ready_i;

endmodule

// File: hw/axi_lite_regs_pkg.sv
package axi_lite_regs_pkg;

  // Register map geometry
  localparam int unsigned NUM_REGS   = 4;
  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  // Registers are narrower than the bus, zero extended on reads
  localparam int unsigned REG_WIDTH  = 16;
  localparam int unsigned IDX_WIDTH  = 2;

  // Vector types with a meaning of their own
  typedef logic [ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [DATA_WIDTH-1:0] axi_data_t;
  typedef logic [STRB_WIDTH-1:0] axi_strb_t;
  typedef logic [2:0]            axi_prot_t;
  typedef logic [1:0]            axi_resp_t;
  typedef logic [REG_WIDTH-1:0]  reg_data_t;
  typedef logic [IDX_WIDTH-1:0]  reg_idx_t;

  // Slot 2 mirrors its init input and ignores writes
  localparam logic [NUM_REGS-1:0] READ_ONLY = 4'b0100;

  // Protection checking, AxPROT[0] privileged, AxPROT[1] secure
  localparam bit PRIV_PROT_ONLY = 1'b1;
  localparam bit SECU_PROT_ONLY = 1'b0;

  // Word returned on a failed read
  localparam axi_data_t ERR_DATA = 32'hDEADBEEF;

  // AXI response encodings
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Payload widths of the response buffers
  localparam int unsigned B_WIDTH = 2;
  localparam int unsigned R_WIDTH = DATA_WIDTH + 2;

endpackage

// File: hw/axi_lite_regs_top.sv
`timescale 1ns/1ns

module axi_lite_regs_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // AW channel
  input  axi_lite_regs_pkg::axi_addr_t aw_addr_i,
  input  axi_lite_regs_pkg::axi_prot_t aw_prot_i,
  input  logic                         aw_valid_i,
  output logic                         aw_ready_o,
  // W channel
  input  axi_lite_regs_pkg::axi_data_t w_data_i,
  input  axi_lite_regs_pkg::axi_strb_t w_strb_i,
  input  logic                         w_valid_i,
  output logic                         w_ready_o,
  // B channel
  output axi_lite_regs_pkg::axi_resp_t b_resp_o,
  output logic                         b_valid_o,
  input  logic                         b_ready_i,
  // AR channel
  input  axi_lite_regs_pkg::axi_addr_t ar_addr_i,
  input  axi_lite_regs_pkg::axi_prot_t ar_prot_i,
  input  logic                         ar_valid_i,
  output logic                         ar_ready_o,
  // R channel
  output axi_lite_regs_pkg::axi_data_t r_data_o,
  output axi_lite_regs_pkg::axi_resp_t r_resp_o,
  output logic                         r_valid_o,
  input  logic                         r_ready_i,
  // Map base and register values
  input  axi_lite_regs_pkg::axi_addr_t base_addr_i,
  input  logic [axi_lite_regs_pkg::NUM_REGS*axi_lite_regs_pkg::REG_WIDTH-1:0] reg_init_i,
  output logic [axi_lite_regs_pkg::NUM_REGS*axi_lite_regs_pkg::REG_WIDTH-1:0] reg_q_o
);
  import axi_lite_regs_pkg::*;

  // Core side of the B buffer
  logic               core_b_valid;
  logic               core_b_ready;
  logic [B_WIDTH-1:0] core_b_payload;

  // Core side of the R buffer
  logic               core_r_valid;
  logic               core_r_ready;
  logic [R_WIDTH-1:0] core_r_payload;
  logic [R_WIDTH-1:0] r_payload;

  axi_lite_regs u_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .aw_addr_i   (aw_addr_i),
    .aw_prot_i   (aw_prot_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .b_valid_o   (core_b_valid),
    .b_ready_i   (core_b_ready),
    .b_payload_o (core_b_payload),
    .ar_addr_i   (ar_addr_i),
    .ar_prot_i   (ar_prot_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .r_valid_o   (core_r_valid),
    .r_ready_i   (core_r_ready),
    .r_payload_o (core_r_payload),
    .base_addr_i (base_addr_i),
    .reg_init_i  (reg_init_i),
    .reg_q_o     (reg_q_o)
  );

  // Cuts comb paths between B ready and AW/W ready
  spill_register #(
    .Width (B_WIDTH)
  ) u_b_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (core_b_valid),
    .ready_o (core_b_ready),
    .data_i  (core_b_payload),
    .valid_o (b_valid_o),
    .ready_i (b_ready_i),
    .data_o  (b_resp_o)
  );

  // Same for the read response path
  spill_register #(
    .Width (R_WIDTH)
  ) u_r_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (core_r_valid),
    .ready_o (core_r_ready),
    .data_i  (core_r_payload),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i),
    .data_o  (r_payload)
  );

  // Split R payload back into data and resp
  assign r_data_o = r_payload[R_WIDTH-1:2];
  assign r_resp_o = r_payload[1:0];

endmodule

// File: hw/reg_addr_decode.sv
`timescale 1ns/1ns

module reg_addr_decode (
  input  axi_lite_regs_pkg::axi_addr_t addr_i,
  input  axi_lite_regs_pkg::axi_addr_t base_addr_i,
  output axi_lite_regs_pkg::reg_idx_t  idx_o,
  output logic                         hit_o
);
  import axi_lite_regs_pkg::*;

  // Slot bounds, start inclusive and end exclusive
  axi_addr_t slot_start [NUM_REGS];
  axi_addr_t slot_end   [NUM_REGS];

  // Each register takes one bus word
  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_slots
    assign slot_start[i] = base_addr_i + axi_addr_t'(i * STRB_WIDTH);
    assign slot_end[i]   = base_addr_i + axi_addr_t'((i + 1) * STRB_WIDTH);
  end

  // Slots never overlap so at most one matches
  always_comb begin
    // Miss gives index 0 and no hit
    idx_o = '0;
    hit_o = 1'b0;
    for (int unsigned i = 0; i < NUM_REGS; i++) begin
      if ((addr_i >= slot_start[i]) && (addr_i < slot_end[i])) begin
        idx_o = reg_idx_t'(i);
        hit_o = 1'b1;
      end
    end
  end

endmodule

// File: hw/spill_register.sv
`timescale 1ns/1ns

module spill_register #(
  parameter int unsigned Width = 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Upstream side
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  // Downstream side
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  // Output slot feeds the downstream side directly
  logic             out_full;
  logic [Width-1:0] out_data;
  // Spill slot catches a second entry while output is stalled
  logic             spill_full;
  logic [Width-1:0] spill_data;

  logic push;
  logic pop;

  // Ready comes from a flop only, no path from ready_i
  assign ready_o = ~spill_full;
  assign valid_o = out_full;
  assign data_o  = out_data;

  assign push = valid_i & ready_o;
  assign pop  = out_full & ready_i;

  // Occupancy flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_full   <= 1'b0;
      spill_full <= 1'b0;
    end else begin
      if (pop) begin
        // Spill entry moves up, or a new entry replaces the popped one
        if (!spill_full) begin
          out_full <= push;
        end
        spill_full <= 1'b0;
      end else if (push) begin
        if (out_full) begin
          spill_full <= 1'b1;
        end else begin
          out_full <= 1'b1;
        end
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (spill_full) begin
        out_data <= spill_data;
      end else if (push) begin
        out_data <= data_i;
      end
    end else if (push) begin
      if (out_full) begin
        spill_data <= data_i;
      end else begin
        out_data <= data_i;
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_axi_lite_regs \
  -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  echo "Test run passed"
  exit 0
else
  echo "Test run failed, see sim.log"
  exit 1
fi

// File: tests/axi_lite_regs_props.sv
`timescale 1ns/1ns

module axi_lite_regs_props (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         aw_ready_i,
  input logic                         w_ready_i,
  input logic                         b_valid_i,
  input logic                         b_ready_i,
  input axi_lite_regs_pkg::axi_resp_t b_resp_i,
  input logic                         r_valid_i,
  input logic                         r_ready_i,
  input axi_lite_regs_pkg::axi_data_t r_data_i,
  input axi_lite_regs_pkg::axi_resp_t r_resp_i
);

  // Number of failed assertions so far
  int fail_count = 0;

  // A stalled B response stays put until the master takes it
  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (b_valid_i && !b_ready_i) |=> (b_valid_i && $stable(b_resp_i)))
    else begin
      fail_count++;
      $error("B response dropped or changed before b_ready");
    end

  // Same rule on R, data and resp both frozen
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_data_i) && $stable(r_resp_i)))
    else begin
      fail_count++;
      $error("R response dropped or changed before r_ready");
    end

  // AW and W are always taken together
  aw_w_ready_equal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_ready_i == w_ready_i)
    else begin
      fail_count++;
      $error("aw_ready and w_ready differ");
    end

  // No response may leave while reset is held
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (!b_valid_i && !r_valid_i))
    else begin
      fail_count++;
      $error("Response valid during reset");
    end

endmodule

// File: tests/tb_axi_lite_regs.sv
`timescale 1ns/1ns

module tb_axi_lite_regs;
  import axi_lite_regs_pkg::*;

  localparam axi_addr_t BASE = 16'h1000;
  // Register 3 down to register 0
  localparam logic [NUM_REGS*REG_WIDTH-1:0] INIT = 64'hA5A5_3C3C_1234_BEEF;

  logic      clk;
  logic      rst_n;
  axi_addr_t aw_addr;
  axi_prot_t aw_prot;
  logic      aw_valid;
  logic      aw_ready;
  axi_data_t w_data;
  axi_strb_t w_strb;
  logic      w_valid;
  logic      w_ready;
  axi_resp_t b_resp;
  logic      b_valid;
  logic      b_ready;
  axi_addr_t ar_addr;
  axi_prot_t ar_prot;
  logic      ar_valid;
  logic      ar_ready;
  axi_data_t r_data;
  axi_resp_t r_resp;
  logic      r_valid;
  logic      r_ready;
  axi_addr_t base_addr;
  logic [NUM_REGS*REG_WIDTH-1:0] reg_init;
  logic [NUM_REGS*REG_WIDTH-1:0] reg_q;

  int          errors;
  int          checks;
  // Expected register contents, slot 2 keeps its init value
  reg_data_t   model [NUM_REGS];

  axi_lite_regs_top uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .aw_addr_i   (aw_addr),
    .aw_prot_i   (aw_prot),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .w_data_i    (w_data),
    .w_strb_i    (w_strb),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .b_resp_o    (b_resp),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .ar_addr_i   (ar_addr),
    .ar_prot_i   (ar_prot),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .r_data_o    (r_data),
    .r_resp_o    (r_resp),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .base_addr_i (base_addr),
    .reg_init_i  (reg_init),
    .reg_q_o     (reg_q)
  );

  bind axi_lite_regs_top axi_lite_regs_props u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_ready_i (aw_ready_o),
    .w_ready_i  (w_ready_o),
    .b_valid_i  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_i   (b_resp_o),
    .r_valid_i  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_i   (r_data_o),
    .r_resp_i   (r_resp_o)
  );

  always #4 clk = ~clk;

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_resp(input string test, input axi_resp_t exp, input axi_resp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: resp expected %h actual %h", test, exp, act);
    end
  endtask

  task automatic check_data(input string test, input axi_data_t exp, input axi_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: data expected %h actual %h", test, exp, act);
    end
  endtask

  task automatic check_reg(input string test, input reg_data_t exp, input reg_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: reg_q expected %h actual %h", test, exp, act);
    end
  endtask

  // Four word slots from BASE upward
  function automatic logic slot_hit(input axi_addr_t addr);
    return (addr >= BASE) && (addr < BASE + 16'd16);
  endfunction

  function automatic int slot_idx(input axi_addr_t addr);
    return int'((addr - BASE) >> 2);
  endfunction

  // Reference model of a write, returns the expected B resp
  task automatic model_write(input axi_addr_t addr, input axi_prot_t prot,
                             input axi_data_t data, input axi_strb_t strb,
                             output axi_resp_t resp);
    int idx;
    idx = slot_idx(addr);
    if (slot_hit(addr) && prot[0] && !READ_ONLY[idx]) begin
      // Only the two low bytes exist in a register
      for (int b = 0; b < 2; b++) begin
        if (strb[b]) begin
          model[idx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
      resp = RESP_OKAY;
    end else begin
      resp = RESP_SLVERR;
    end
  endtask

  task automatic model_read(input axi_addr_t addr, input axi_prot_t prot,
                            output axi_data_t data, output axi_resp_t resp);
    if (slot_hit(addr) && prot[0]) begin
      data = axi_data_t'(model[slot_idx(addr)]);
      resp = RESP_OKAY;
    end else begin
      data = ERR_DATA;
      resp = RESP_SLVERR;
    end
  endtask

  // Holds AW and W until both readies are seen at mid cycle
  task automatic axi_write(input axi_addr_t addr, input axi_prot_t prot,
                           input axi_data_t data, input axi_strb_t strb,
                           input bit must_accept, output bit accepted);
    int cnt;
    aw_addr  = addr;
    aw_prot  = prot;
    w_data   = data;
    w_strb   = strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    accepted = 1'b0;
    cnt      = 0;
    while (!accepted && cnt < 100) begin
      @(negedge clk);
      if (aw_ready && w_ready) begin
        accepted = 1'b1;
      end
      next_cycle();
      cnt++;
    end
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    if (!accepted && must_accept) begin
      errors++;
      $display("Timeout: write to address %h was never accepted", addr);
    end
  endtask

  task automatic axi_read(input axi_addr_t addr, input axi_prot_t prot,
                          input bit must_accept, output bit accepted);
    int cnt;
    ar_addr  = addr;
    ar_prot  = prot;
    ar_valid = 1'b1;
    accepted = 1'b0;
    cnt      = 0;
    while (!accepted && cnt < 100) begin
      @(negedge clk);
      if (ar_ready) begin
        accepted = 1'b1;
      end
      next_cycle();
      cnt++;
    end
    ar_valid = 1'b0;
    if (!accepted && must_accept) begin
      errors++;
      $display("Timeout: read of address %h was never accepted", addr);
    end
  endtask

  // b_ready is expected high while waiting here
  task automatic get_b(input string test, output axi_resp_t resp);
    int cnt;
    bit got;
    got  = 1'b0;
    cnt  = 0;
    resp = 'x;
    while (!got && cnt < 100) begin
      @(negedge clk);
      if (b_valid) begin
        resp = b_resp;
        got  = 1'b1;
      end
      next_cycle();
      cnt++;
    end
    if (!got) begin
      errors++;
      $display("Timeout: no write response arrived in test %s", test);
    end
  endtask

  task automatic get_r(input string test, output axi_data_t data, output axi_resp_t resp);
    int cnt;
    bit got;
    got  = 1'b0;
    cnt  = 0;
    data = 'x;
    resp = 'x;
    while (!got && cnt < 100) begin
      @(negedge clk);
      if (r_valid) begin
        data = r_data;
        resp = r_resp;
        got  = 1'b1;
      end
      next_cycle();
      cnt++;
    end
    if (!got) begin
      errors++;
      $display("Timeout: no read response arrived in test %s", test);
    end
  endtask

  task automatic write_check(input string test, input axi_addr_t addr, input axi_prot_t prot,
                             input axi_data_t data, input axi_strb_t strb);
    bit        acc;
    axi_resp_t exp_resp;
    axi_resp_t act_resp;
    model_write(addr, prot, data, strb, exp_resp);
    axi_write(addr, prot, data, strb, 1'b1, acc);
    if (acc) begin
      get_b(test, act_resp);
      check_resp(test, exp_resp, act_resp);
    end
  endtask

  task automatic read_check(input string test, input axi_addr_t addr, input axi_prot_t prot);
    bit        acc;
    axi_data_t exp_data;
    axi_resp_t exp_resp;
    axi_data_t act_data;
    axi_resp_t act_resp;
    model_read(addr, prot, exp_data, exp_resp);
    axi_read(addr, prot, 1'b1, acc);
    if (acc) begin
      get_r(test, act_data, act_resp);
      check_resp(test, exp_resp, act_resp);
      check_data(test, exp_data, act_data);
    end
  endtask

  // reg_q_o and a privileged readback of every slot
  task automatic check_regs(input string test);
    for (int i = 0; i < NUM_REGS; i++) begin
      check_reg(test, model[i], reg_q[i*REG_WIDTH +: REG_WIDTH]);
      read_check(test, BASE + axi_addr_t'(i * 4), 3'b001);
    end
  endtask

  task automatic test_priv_writes();
    // Upper half of the bus word is dropped
    write_check("priv_full", BASE, 3'b001, 32'hFFFF_5A5A, 4'hF);
    write_check("priv_full", BASE + 16'h4, 3'b011, 32'h0000_C001, 4'hF);
    write_check("priv_partial", BASE, 3'b001, 32'h0000_7711, 4'b0001);
    // Byte 2 is strobed but lies above the register
    write_check("priv_partial", BASE + 16'hC, 3'b101, 32'h0055_9900, 4'b0110);
    check_regs("priv_writes");
  endtask

  task automatic test_rejected_writes();
    write_check("ro_write", BASE + 16'h8, 3'b001, 32'h0000_1111, 4'hF);
    write_check("unpriv_write", BASE, 3'b010, 32'h0000_2222, 4'hF);
    write_check("oor_write", BASE + 16'h10, 3'b001, 32'h0000_3333, 4'hF);
    write_check("oor_write", 16'h0FFC, 3'b001, 32'h0000_4444, 4'hF);
    check_regs("rejected_writes");
  endtask

  task automatic test_failing_reads();
    read_check("oor_read", BASE + 16'h20, 3'b001);
    read_check("oor_read", 16'h0FFC, 3'b001);
    read_check("unpriv_read", BASE + 16'h4, 3'b000);
  endtask

  task automatic test_backpressure();
    bit        a1;
    bit        a2;
    bit        a3;
    axi_resp_t exp1;
    axi_resp_t exp2;
    axi_resp_t act;
    axi_data_t exp_d1;
    axi_data_t exp_d2;
    axi_data_t act_d;
    // Stalled B path, OKAY then SLVERR so the order shows
    b_ready = 1'b0;
    model_write(BASE, 3'b001, 32'h0000_4321, 4'hF, exp1);
    axi_write(BASE, 3'b001, 32'h0000_4321, 4'hF, 1'b1, a1);
    model_write(BASE + 16'h8, 3'b001, 32'h0000_FFFF, 4'hF, exp2);
    axi_write(BASE + 16'h8, 3'b001, 32'h0000_FFFF, 4'hF, 1'b1, a2);
    // Third write misses the map so its stall cannot touch a register
    axi_write(BASE + 16'h40, 3'b001, 32'h0000_0BAD, 4'hF, 1'b0, a3);
    if (!a1 || !a2 || a3) begin
      errors++;
      $display("[ERROR] bp_write: accepted writes expected 2 actual %0d",
               int'(a1) + int'(a2) + int'(a3));
    end
    b_ready = 1'b1;
    get_b("bp_write", act);
    check_resp("bp_write", exp1, act);
    get_b("bp_write", act);
    check_resp("bp_write", exp2, act);

    // Same on the read side
    r_ready = 1'b0;
    model_read(BASE + 16'h4, 3'b001, exp_d1, exp1);
    axi_read(BASE + 16'h4, 3'b001, 1'b1, a1);
    model_read(BASE + 16'h30, 3'b001, exp_d2, exp2);
    axi_read(BASE + 16'h30, 3'b001, 1'b1, a2);
    axi_read(BASE, 3'b001, 1'b0, a3);
    if (!a1 || !a2 || a3) begin
      errors++;
      $display("[ERROR] bp_read: accepted reads expected 2 actual %0d",
               int'(a1) + int'(a2) + int'(a3));
    end
    r_ready = 1'b1;
    get_r("bp_read", act_d, act);
    check_resp("bp_read", exp1, act);
    check_data("bp_read", exp_d1, act_d);
    get_r("bp_read", act_d, act);
    check_resp("bp_read", exp2, act);
    check_data("bp_read", exp_d2, act_d);
    check_regs("backpressure");
  endtask

  task automatic test_random();
    logic [31:0] rnd;
    axi_addr_t   addr;
    axi_data_t   data;
    // Word addresses 0x0FF8 to 0x1014, so both edges of the map get hit
    for (int n = 0; n < 40; n++) begin
      rnd  = $urandom;
      data = $urandom;
      addr = 16'h0FF8 + axi_addr_t'({rnd[2:0], 2'b00});
      if (rnd[10]) begin
        write_check("random_write", addr, rnd[5:3], data, rnd[9:6]);
      end else begin
        read_check("random_read", addr, rnd[5:3]);
      end
    end
    check_regs("random");
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    aw_addr   = '0;
    aw_prot   = '0;
    aw_valid  = 1'b0;
    w_data    = '0;
    w_strb    = '0;
    w_valid   = 1'b0;
    b_ready   = 1'b1;
    ar_addr   = '0;
    ar_prot   = '0;
    ar_valid  = 1'b0;
    r_ready   = 1'b1;
    base_addr = BASE;
    reg_init  = INIT;
    errors    = 0;
    checks    = 0;
    void'($urandom(40));
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = INIT[i*REG_WIDTH +: REG_WIDTH];
    end

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    check_regs("reset");
    test_priv_writes();
    test_rejected_writes();
    test_failing_reads();
    test_backpressure();
    test_random();

    // Bound assertion failures add to the total
    errors += uut.u_props.fail_count;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
